// ==== list.f ====
source/n64VideoPkg.sv
source/n64PixelIf.sv
source/n64ScanlineShader.sv
source/n64VideoDemux.sv
source/n64OutputStage.sv
source/n64VideoTop.sv
verification/n64Video_asserts.sv
verification/n64VideoTb.sv

// ==== verification/n64VideoTb.sv ====
//////////////////////////////////////////////////////////////////////
// N64 video path testbench: random pixel stream, transmitter credit
// model and reference model of the shaded output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module n64VideoTb;

  localparam int CW = n64VideoPkg::COLOR_IN_WIDTH;
  localparam int OW = n64VideoPkg::COLOR_OUT_WIDTH;
  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 16;
  localparam int LINE_PIXELS = 16;
  localparam int FRAME_LINES = 4;
  // Idle cycles without output before a drain gives up
  localparam int QUIET_LIMIT = 32;

  // Downstream credit return modes
  localparam int CREDIT_FAST = 0;
  localparam int CREDIT_RANDOM = 1;
  localparam int CREDIT_HOLD = 2;

  // Run length budget for the watchdog
  localparam int STREAM_PIXELS = 416;
  localparam int ABORT_CYCLES = 192;
  localparam int DRAIN_CYCLES = 5 * 64;
  localparam int MARGIN_CYCLES = 200;
  localparam int RUN_CYCLES = RESET_CYCLES + 4 * STREAM_PIXELS + ABORT_CYCLES + DRAIN_CYCLES;
  localparam int WATCHDOG_NS = (RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  // One sent pixel as the model keeps it
  typedef struct packed {
    n64VideoPkg::syncFlagsT sync;
    logic [CW-1:0]          red;
    logic [CW-1:0]          green;
    logic [CW-1:0]          blue;
  } pixelT;

  // DUT ports
  logic            VCLK_0;
  logic            arstN_i;
  logic            nVDSYNC_i;
  logic [CW-1:0]   vd_i;
  logic            cfgScanline_i;
  logic            txCredit_i;
  logic            vdValid_o;
  logic            vSyncN_o;
  logic            hSyncN_o;
  logic            cSyncN_o;
  logic [3*OW-1:0] vd_o;
  logic            overflow_o;

  // Model state
  pixelT refQueue[$];
  logic  mdlOdd;
  logic  mdlPrevH;
  // Stimulus controls
  int    creditMode;
  logic  cfgSetting;
  logic  skipAllowed;
  // Pixels delivered downstream and not yet credited back
  int    outstanding;
  // Bookkeeping
  int    outCount;
  int    skipCount;
  int    dimCount;
  int    errorCount;
  int    outBefore;

  n64VideoTop UUT (
    .VCLK_0        (VCLK_0),
    .arstN_i       (arstN_i),
    .nVDSYNC_i     (nVDSYNC_i),
    .vd_i          (vd_i),
    .cfgScanline_i (cfgScanline_i),
    .txCredit_i    (txCredit_i),
    .vdValid_o     (vdValid_o),
    .vSyncN_o      (vSyncN_o),
    .hSyncN_o      (hSyncN_o),
    .cSyncN_o      (cSyncN_o),
    .vd_o          (vd_o),
    .overflow_o    (overflow_o)
  );

  always #(CLK_PERIOD / 2) VCLK_0 = !VCLK_0;

  //////////////////////////////////////////////////////////////////////
  // Reference model

  // 7 to 8 bits by repeating the MSB, halved on dimmed lines
  function automatic logic [OW-1:0] expandColor(input logic [CW-1:0] color, input logic halve);
    logic [OW-1:0] wide;
    wide = OW'(color) << 1;
    wide[0] = color[CW-1];
    if (halve) begin
      wide = {1'b0, wide[OW-1:1]};
    end
    return wide;
  endfunction

  // Line parity once this pixel is out
  function automatic logic nextParity(input n64VideoPkg::syncFlagsT sync);
    if (!sync.vsyncN) begin
      return 1'b0;
    end
    if (!sync.hsyncN && mdlPrevH) begin
      return !mdlOdd;
    end
    return mdlOdd;
  endfunction

  task automatic checkField(input string name, input logic [3*OW-1:0] expVal,
                            input logic [3*OW-1:0] actVal);
    assert (actVal === expVal) else begin
      errorCount++;
      $display("Error at %0t ns: %s expected %0h, actual %0h", $time, name, expVal, actVal);
    end
  endtask

  // Match one output pixel, skipping dropped ones when allowed
  task automatic checkPixel();
    pixelT           cand;
    logic            matched;
    logic            parity;
    logic            dim;
    logic [3*OW-1:0] expVd;
    matched = 1'b0;
    while (!matched && refQueue.size() > 0) begin
      cand = refQueue.pop_front();
      parity = nextParity(cand.sync);
      dim = cfgScanline_i && parity;
      expVd = {expandColor(cand.red, dim), expandColor(cand.green, dim),
               expandColor(cand.blue, dim)};
      if (!skipAllowed || (expVd === vd_o && cand.sync.vsyncN === vSyncN_o &&
          cand.sync.hsyncN === hSyncN_o && cand.sync.csyncN === cSyncN_o)) begin
        matched = 1'b1;
      end else begin
        skipCount++;
      end
    end
    assert (matched) else begin
      errorCount++;
      $display("Output pixel at %0t ns matches no sent pixel", $time);
    end
    if (matched) begin
      checkField("vd_o", expVd, vd_o);
      checkField("vSyncN_o", cand.sync.vsyncN, vSyncN_o);
      checkField("hSyncN_o", cand.sync.hsyncN, hSyncN_o);
      checkField("cSyncN_o", cand.sync.csyncN, cSyncN_o);
      mdlOdd = parity;
      mdlPrevH = cand.sync.hsyncN;
      if (dim) begin
        dimCount++;
      end
    end
  endtask

  // Outputs change on the rising edge, look at them on the falling one
  always @(negedge VCLK_0) begin
    if (arstN_i && vdValid_o) begin
      outstanding = outstanding + 1;
      outCount++;
      assert (outstanding <= n64VideoPkg::TX_CREDITS) else begin
        errorCount++;
        $display("Transmitter overrun at %0t ns: %0d pixels outstanding", $time, outstanding);
      end
      checkPixel();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  // One bus cycle plus the downstream credit decision
  task automatic driveCycle(input logic nSync, input logic [CW-1:0] data);
    logic giveCredit;
    @(posedge VCLK_0);
    nVDSYNC_i <= nSync;
    vd_i <= data;
    cfgScanline_i <= cfgSetting;
    case (creditMode)
      CREDIT_FAST:   giveCredit = (outstanding > 0);
      CREDIT_RANDOM: giveCredit = (outstanding > 0) && ($urandom_range(0, 1) == 0);
      default:       giveCredit = 1'b0;
    endcase
    txCredit_i <= giveCredit;
    if (giveCredit) begin
      outstanding = outstanding - 1;
    end
  endtask

  // Sync plus one or two colours, then cut short by the next sync
  task automatic sendFragment();
    int colours;
    colours = $urandom_range(1, 2);
    driveCycle(1'b0, CW'($urandom));
    repeat (colours) driveCycle(1'b1, CW'($urandom));
  endtask

  task automatic sendPixel(input pixelT pix);
    driveCycle(1'b0, {3'($urandom), pix.sync});
    driveCycle(1'b1, pix.red);
    driveCycle(1'b1, pix.green);
    driveCycle(1'b1, pix.blue);
    refQueue.push_back(pix);
  endtask

  // Pixels first .. first+count-1 of a stream of 16-pixel lines, 4-line frames
  task automatic sendStream(input int first, input int count, input int abortPct);
    pixelT pix;
    int    col;
    int    line;
    for (int i = first; i < first + count; i++) begin
      col = i % LINE_PIXELS;
      line = (i / LINE_PIXELS) % FRAME_LINES;
      pix.sync.vsyncN = !(col == 0 && line == 0);
      pix.sync.hsyncN = (col != 0);
      pix.sync.clampN = 1'($urandom_range(0, 1));
      pix.sync.csyncN = pix.sync.vsyncN && pix.sync.hsyncN;
      pix.red = CW'($urandom);
      pix.green = CW'($urandom);
      pix.blue = CW'($urandom);
      if ($urandom_range(0, 99) < abortPct) begin
        sendFragment();
      end
      sendPixel(pix);
    end
  endtask

  // Idle bus with fast credits until the model is empty or output stops
  task automatic drainOutput(input logic expectEmpty);
    int quiet;
    int lastOut;
    quiet = 0;
    creditMode = CREDIT_FAST;
    while ((refQueue.size() != 0 || outstanding != 0) && quiet < QUIET_LIMIT) begin
      lastOut = outCount;
      driveCycle(1'b1, '0);
      quiet = (outCount == lastOut) ? quiet + 1 : 0;
    end
    if (expectEmpty) begin
      assert (refQueue.size() == 0) else begin
        errorCount++;
        $display("%0d sent pixels never came out", refQueue.size());
      end
    end
    refQueue.delete();
  endtask

  task automatic checkOverflow(input logic expected);
    @(negedge VCLK_0);
    checkField("overflow_o", expected, overflow_o);
  endtask

  function automatic int assertFailures();
    return UUT.videoDemux.demuxChecks.assertFails + UUT.outputStage.stageChecks.assertFails;
  endfunction

  task automatic reportCounts();
    $display("Summary: %0d check errors, %0d assertion failures, %0d pixels out, %0d skipped",
             errorCount, assertFailures(), outCount, skipCount);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    VCLK_0 = 1'b0;
    arstN_i = 1'b0;
    nVDSYNC_i = 1'b1;
    vd_i = '0;
    cfgScanline_i = 1'b0;
    txCredit_i = 1'b0;
    mdlOdd = 1'b0;
    mdlPrevH = 1'b1;
    creditMode = CREDIT_FAST;
    cfgSetting = 1'b0;
    skipAllowed = 1'b0;
    outstanding = 0;
    outCount = 0;
    skipCount = 0;
    dimCount = 0;
    errorCount = 0;
    void'($urandom(63));
    repeat (RESET_CYCLES) @(posedge VCLK_0);
    arstN_i <= 1'b1;

    // In-order streaming with fast credits
    sendStream(0, 128, 0);
    drainOutput(1'b1);
    checkOverflow(1'b0);

    // Scanlines on, odd lines come out dimmed
    cfgSetting = 1'b1;
    dimCount = 0;
    sendStream(0, 128, 0);
    drainOutput(1'b1);
    checkOverflow(1'b0);
    assert (dimCount > 0) else begin
      errorCount++;
      $display("No dimmed pixel seen with scanlines enabled");
    end

    // Restarted pixels under random credit return
    cfgSetting = 1'b0;
    creditMode = CREDIT_RANDOM;
    sendStream(0, 64, 25);
    drainOutput(1'b1);
    checkOverflow(1'b0);

    // Credits withheld, just short of filling the FIFO
    creditMode = CREDIT_HOLD;
    sendStream(0, 10, 0);
    assert (outstanding == n64VideoPkg::TX_CREDITS) else begin
      errorCount++;
      $display("Credits withheld, yet %0d pixels went out", outstanding);
    end
    creditMode = CREDIT_FAST;
    sendStream(10, 22, 0);
    drainOutput(1'b1);
    checkOverflow(1'b0);

    // Long starvation drops pixels, the flag is sticky
    cfgSetting = 1'b1;
    skipAllowed = 1'b1;
    outBefore = outCount;
    creditMode = CREDIT_HOLD;
    sendStream(0, 40, 0);
    checkOverflow(1'b1);
    creditMode = CREDIT_RANDOM;
    sendStream(40, 24, 0);
    drainOutput(1'b0);
    checkOverflow(1'b1);
    assert (outCount > outBefore) else begin
      errorCount++;
      $display("No pixel came out while starved");
    end

    reportCounts();
    if (errorCount + assertFailures() == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog sized from the stimulus length
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    reportCounts();
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/n64Video_asserts.sv ====
//////////////////////////////////////////////////////////////////////
// Credit link checks, bound into the demux and the output stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module n64VideoAsserts (
  input logic       VCLK_0,
  input logic       arstN_i,
  // Sender side of a credit link
  input logic       send_i,
  input logic [7:0] credits_i,
  input logic [7:0] creditMax_i,
  // Receiver side, credit pulse and entries held
  input logic       creditPulse_i,
  input logic [7:0] occupied_i
);

  // Failures seen so far
  int assertFails = 0;

  // Never send without a credit in hand
  sendNeedsCredit: assert property (
    @(posedge VCLK_0) disable iff (!arstN_i) send_i |-> (credits_i != '0)
  ) else begin
    assertFails++;
    $error("Send with zero credits");
  end

  // Count never climbs above its reset value
  creditBounded: assert property (
    @(posedge VCLK_0) disable iff (!arstN_i) credits_i <= creditMax_i
  ) else begin
    assertFails++;
    $error("Credit count %0d above %0d", credits_i, creditMax_i);
  end

  // A credit is only returned for an entry that exists
  creditNeedsEntry: assert property (
    @(posedge VCLK_0) disable iff (!arstN_i) creditPulse_i |-> (occupied_i != '0)
  ) else begin
    assertFails++;
    $error("Credit returned with nothing outstanding");
  end

endmodule

// Pixel link seen from the demux, credits plus FIFO level is the FIFO depth
bind n64VideoDemux n64VideoAsserts demuxChecks (
  .VCLK_0        (VCLK_0),
  .arstN_i       (arstN_i),
  .send_i        (pixOut.pixValid),
  .credits_i     (8'(credits)),
  .creditMax_i   (8'(n64VideoPkg::PIXEL_FIFO_DEPTH)),
  .creditPulse_i (pixOut.credit),
  .occupied_i    (8'(n64VideoPkg::PIXEL_FIFO_DEPTH) - 8'(credits))
);

// Transmitter link seen from the output stage
bind n64OutputStage n64VideoAsserts stageChecks (
  .VCLK_0        (VCLK_0),
  .arstN_i       (arstN_i),
  .send_i        (vdValid_o),
  .credits_i     (8'(txCredits)),
  .creditMax_i   (8'(n64VideoPkg::TX_CREDITS)),
  .creditPulse_i (txCredit_i),
  .occupied_i    (8'(n64VideoPkg::TX_CREDITS) - 8'(txCredits))
);

`default_nettype wire

// ==== source/n64VideoTop.sv ====
//////////////////////////////////////////////////////////////////////
// N64 video path top level: demux and output stage on one pixel link
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module n64VideoTop (
  // N64 video input
  input  logic                                      VCLK_0,
  input  logic                                      arstN_i,
  input  logic                                      nVDSYNC_i,
  input  logic [n64VideoPkg::COLOR_IN_WIDTH-1:0]    vd_i,

  // Configuration and transmitter credit return
  input  logic                                      cfgScanline_i,
  input  logic                                      txCredit_i,

  // Video towards the transmitter
  output logic                                      vdValid_o,
  output logic                                      vSyncN_o,
  output logic                                      hSyncN_o,
  output logic                                      cSyncN_o,
  output logic [3*n64VideoPkg::COLOR_OUT_WIDTH-1:0] vd_o,

  // Sticky, a pixel was lost
  output logic                                      overflow_o
);

  // Internal pixel link
  n64PixelIf pixLink ();

  // Bus phases to pixels
  n64VideoDemux videoDemux (
    .VCLK_0     (VCLK_0),
    .arstN_i    (arstN_i),
    .nVDSYNC_i  (nVDSYNC_i),
    .vd_i       (vd_i),
    .overflow_o (overflow_o),
    .pixOut     (pixLink.sender)
  );

  // FIFO, shading and transmitter handshake
  n64OutputStage outputStage (
    .VCLK_0        (VCLK_0),
    .arstN_i       (arstN_i),
    .cfgScanline_i (cfgScanline_i),
    .txCredit_i    (txCredit_i),
    .pixIn         (pixLink.receiver),
    .vdValid_o     (vdValid_o),
    .vSyncN_o      (vSyncN_o),
    .hSyncN_o      (hSyncN_o),
    .cSyncN_o      (cSyncN_o),
    .vd_o          (vd_o)
  );

endmodule

`default_nettype wire

// ==== source/n64OutputStage.sv ====
//////////////////////////////////////////////////////////////////////
// Output stage: pixel FIFO with credit return, transmitter credit
// counter and registered shaded output towards the transmitter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module n64OutputStage (
  input  logic                                      VCLK_0,
  input  logic                                      arstN_i,
  input  logic                                      cfgScanline_i,
  input  logic                                      txCredit_i,
  n64PixelIf.receiver                               pixIn,
  output logic                                      vdValid_o,
  output logic                                      vSyncN_o,
  output logic                                      hSyncN_o,
  output logic                                      cSyncN_o,
  output logic [3*n64VideoPkg::COLOR_OUT_WIDTH-1:0] vd_o
);

  //////////////////////////////////////////////////////////////////////
  // Pixel FIFO

  // Storage, one array per field
  logic [n64VideoPkg::COLOR_IN_WIDTH-1:0] fifoRed [n64VideoPkg::PIXEL_FIFO_DEPTH];
  logic [n64VideoPkg::COLOR_IN_WIDTH-1:0] fifoGreen [n64VideoPkg::PIXEL_FIFO_DEPTH];
  logic [n64VideoPkg::COLOR_IN_WIDTH-1:0] fifoBlue [n64VideoPkg::PIXEL_FIFO_DEPTH];
  n64VideoPkg::syncFlagsT                 fifoSync [n64VideoPkg::PIXEL_FIFO_DEPTH];

  n64VideoPkg::fifoPtrT   wrPtr;
  n64VideoPkg::fifoPtrT   rdPtr;
  n64VideoPkg::pixCreditT fifoLevel;

  // Transmitter credits not yet used by a vdValid_o
  n64VideoPkg::txCreditT txCredits;
  // A credit stays free after the pixel already in the output register
  logic txReady;
  logic pop;

  // Shaded colour of the head entry
  logic [3*n64VideoPkg::COLOR_OUT_WIDTH-1:0] shadedVd;

  // Writes never find the FIFO full, the link credits guarantee that
  always_ff @(posedge VCLK_0) begin
    if (pixIn.pixValid) begin
      fifoRed[wrPtr]   <= pixIn.red;
      fifoGreen[wrPtr] <= pixIn.green;
      fifoBlue[wrPtr]  <= pixIn.blue;
      fifoSync[wrPtr]  <= pixIn.sync;
    end
  end

  assign txReady = txCredits > vdValid_o;
  assign pop = (fifoLevel != '0) && txReady;

  // Each freed entry goes straight back to the demux as a credit
  assign pixIn.credit = pop;

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge VCLK_0 or negedge arstN_i) begin
    if (!arstN_i) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      fifoLevel <= '0;
    end else begin
      if (pixIn.pixValid) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      fifoLevel <= fifoLevel + pixIn.pixValid - pop;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Transmitter credits

  // Send and return in one cycle leave the count unchanged
  always_ff @(posedge VCLK_0 or negedge arstN_i) begin
    if (!arstN_i) begin
      txCredits <= n64VideoPkg::txCreditT'(n64VideoPkg::TX_CREDITS);
    end else begin
      txCredits <= txCredits + txCredit_i - vdValid_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Shading and output register

  n64ScanlineShader scanlineShader (
    .VCLK_0        (VCLK_0),
    .arstN_i       (arstN_i),
    .pop_i         (pop),
    .cfgScanline_i (cfgScanline_i),
    .red_i         (fifoRed[rdPtr]),
    .green_i       (fifoGreen[rdPtr]),
    .blue_i        (fifoBlue[rdPtr]),
    .sync_i        (fifoSync[rdPtr]),
    .vd_o          (shadedVd)
  );

  // Control and sync outputs, syncs idle high
  always_ff @(posedge VCLK_0 or negedge arstN_i) begin
    if (!arstN_i) begin
      vdValid_o <= 1'b0;
      vSyncN_o  <= 1'b1;
      hSyncN_o  <= 1'b1;
      cSyncN_o  <= 1'b1;
    end else begin
      vdValid_o <= pop;
      if (pop) begin
        vSyncN_o <= fifoSync[rdPtr].vsyncN;
        hSyncN_o <= fifoSync[rdPtr].hsyncN;
        cSyncN_o <= fifoSync[rdPtr].csyncN;
      end
    end
  end

  // Colour payload
  always_ff @(posedge VCLK_0) begin
    if (pop) begin
      vd_o <= shadedVd;
    end
  end

endmodule

`default_nettype wire

// ==== source/n64VideoDemux.sv ====
//////////////////////////////////////////////////////////////////////
// N64 VD bus demultiplexer: gathers sync, red, green and blue phases
// into one pixel and issues it on the credit-based pixel link
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module n64VideoDemux (
  input  logic                                   VCLK_0,
  input  logic                                   arstN_i,
  input  logic                                   nVDSYNC_i,
  input  logic [n64VideoPkg::COLOR_IN_WIDTH-1:0] vd_i,
  output logic                                   overflow_o,
  n64PixelIf.sender                              pixOut
);

  //////////////////////////////////////////////////////////////////////
  // Phase tracking

  n64VideoPkg::demuxPhaseT phase;
  n64VideoPkg::demuxPhaseT phaseNext;

  // Blue cycle of a pixel that was not restarted by a new sync
  logic blueCycle;
  // Complete pixel and a free FIFO slot downstream
  logic issue;

  // Credits left for the pixel link
  n64VideoPkg::pixCreditT credits;

  // Components held until blue arrives
  n64VideoPkg::syncFlagsT syncHold;
  logic [n64VideoPkg::COLOR_IN_WIDTH-1:0] redHold;
  logic [n64VideoPkg::COLOR_IN_WIDTH-1:0] greenHold;

  always_comb begin
    phaseNext = phase;
    if (!nVDSYNC_i) begin
      // Sync always restarts the sequence, a partial pixel is lost
      phaseNext = n64VideoPkg::PH_RED;
    end else begin
      case (phase)
        n64VideoPkg::PH_RED:   phaseNext = n64VideoPkg::PH_GREEN;
        n64VideoPkg::PH_GREEN: phaseNext = n64VideoPkg::PH_BLUE;
        default:               phaseNext = n64VideoPkg::PH_IDLE;
      endcase
    end
  end

  assign blueCycle = nVDSYNC_i && (phase == n64VideoPkg::PH_BLUE);
  assign issue = blueCycle && (credits != '0);

  always_ff @(posedge VCLK_0 or negedge arstN_i) begin
    if (!arstN_i) begin
      phase <= n64VideoPkg::PH_IDLE;
    end else begin
      phase <= phaseNext;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pixel assembly

  // Capture registers
  always_ff @(posedge VCLK_0) begin
    if (!nVDSYNC_i) begin
      syncHold <= n64VideoPkg::syncFlagsT'(vd_i[3:0]);
    end
    if (nVDSYNC_i && (phase == n64VideoPkg::PH_RED)) begin
      redHold <= vd_i;
    end
    if (nVDSYNC_i && (phase == n64VideoPkg::PH_GREEN)) begin
      greenHold <= vd_i;
    end
    // Blue goes straight into the link payload
    if (issue) begin
      pixOut.red   <= redHold;
      pixOut.green <= greenHold;
      pixOut.blue  <= vd_i;
      pixOut.sync  <= syncHold;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Link handshake, credits and overflow

  always_ff @(posedge VCLK_0 or negedge arstN_i) begin
    if (!arstN_i) begin
      pixOut.pixValid <= 1'b0;
      credits         <= n64VideoPkg::pixCreditT'(n64VideoPkg::PIXEL_FIFO_DEPTH);
      overflow_o      <= 1'b0;
    end else begin
      // Strobe lands one cycle after blue
      pixOut.pixValid <= issue;
      // Credit is spent while pixValid is high, returns land next edge
      credits <= credits + pixOut.credit - pixOut.pixValid;
      // N64 cannot be stalled, so a blocked pixel is dropped and flagged
      if (blueCycle && (credits == '0)) begin
        overflow_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/n64ScanlineShader.sv ====
//////////////////////////////////////////////////////////////////////
// Scanline shader: tracks line parity, expands 7-bit colour to 8 bits
// and halves intensity on odd lines when enabled
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module n64ScanlineShader (
  input  logic                                      VCLK_0,
  input  logic                                      arstN_i,
  input  logic                                      pop_i,
  input  logic                                      cfgScanline_i,
  input  logic [n64VideoPkg::COLOR_IN_WIDTH-1:0]    red_i,
  input  logic [n64VideoPkg::COLOR_IN_WIDTH-1:0]    green_i,
  input  logic [n64VideoPkg::COLOR_IN_WIDTH-1:0]    blue_i,
  input  n64VideoPkg::syncFlagsT                    sync_i,
  output logic [3*n64VideoPkg::COLOR_OUT_WIDTH-1:0] vd_o
);

  // Line parity, high on odd lines
  logic oddLine;
  logic oddLineNext;
  // hsyncN of the last popped pixel, used for edge detection
  logic prevHsyncN;
  // Dim the pixel currently offered
  logic dim;

  // Widen by repeating the MSB, then optionally halve
  function automatic logic [n64VideoPkg::COLOR_OUT_WIDTH-1:0] shade(
    input logic [n64VideoPkg::COLOR_IN_WIDTH-1:0] color,
    input logic                                   halve
  );
    logic [n64VideoPkg::COLOR_OUT_WIDTH-1:0] wide;
    wide = {color, color[n64VideoPkg::COLOR_IN_WIDTH-1]};
    return halve ? (wide >> 1) : wide;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Line parity

  always_comb begin
    oddLineNext = oddLine;
    if (!sync_i.vsyncN) begin
      // Frame start is always an even line
      oddLineNext = 1'b0;
    end else if (!sync_i.hsyncN && prevHsyncN) begin
      // Falling hsync opens a new line
      oddLineNext = !oddLine;
    end
  end

  always_ff @(posedge VCLK_0 or negedge arstN_i) begin
    if (!arstN_i) begin
      oddLine    <= 1'b0;
      prevHsyncN <= 1'b1;
    end else if (pop_i) begin
      oddLine    <= oddLineNext;
      prevHsyncN <= sync_i.hsyncN;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Colour path

  // Parity after this pixel decides, so the first pixel of a line is shaded too
  assign dim = cfgScanline_i && oddLineNext;

  // Red in the top byte, blue in the bottom byte
  assign vd_o = {shade(red_i, dim), shade(green_i, dim), shade(blue_i, dim)};

endmodule

`default_nettype wire

// ==== source/n64PixelIf.sv ====
//////////////////////////////////////////////////////////////////////
// Credit-based pixel link from the demultiplexer to the output stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface n64PixelIf;

  // One cycle strobe, the payload below is valid with it
  logic pixValid;
  logic [n64VideoPkg::COLOR_IN_WIDTH-1:0] red;
  logic [n64VideoPkg::COLOR_IN_WIDTH-1:0] green;
  logic [n64VideoPkg::COLOR_IN_WIDTH-1:0] blue;
  n64VideoPkg::syncFlagsT sync;

  // One cycle pulse per FIFO entry freed by the receiver
  logic credit;

  modport sender (
    output pixValid,
    output red,
    output green,
    output blue,
    output sync,
    input  credit
  );

  modport receiver (
    input  pixValid,
    input  red,
    input  green,
    input  blue,
    input  sync,
    output credit
  );

endinterface

`default_nettype wire

// ==== source/n64VideoPkg.sv ====
//////////////////////////////////////////////////////////////////////
// N64 video path shared definitions: widths, depths, sync flags and
// the demultiplexer phase encoding
//////////////////////////////////////////////////////////////////////

`default_nettype none

package n64VideoPkg;

  // Width of one N64 colour component and of the VD bus
  localparam int COLOR_IN_WIDTH = 7;
  // Width of one colour component towards the transmitter
  localparam int COLOR_OUT_WIDTH = 8;

  // Output stage FIFO entries, also the demux start credit count
  localparam int PIXEL_FIFO_DEPTH = 4;
  // Credits the transmitter grants after reset
  localparam int TX_CREDITS = 8;

  // Counter widths derived from the depths above
  localparam int PIX_CREDIT_WIDTH = $clog2(PIXEL_FIFO_DEPTH + 1);
  localparam int FIFO_PTR_WIDTH = $clog2(PIXEL_FIFO_DEPTH);
  localparam int TX_CREDIT_WIDTH = $clog2(TX_CREDITS + 1);

  // Counts 0 .. PIXEL_FIFO_DEPTH (pixel link credits, FIFO fill level)
  typedef logic [PIX_CREDIT_WIDTH-1:0] pixCreditT;
  // FIFO read and write pointers
  typedef logic [FIFO_PTR_WIDTH-1:0] fifoPtrT;
  // Counts 0 .. TX_CREDITS
  typedef logic [TX_CREDIT_WIDTH-1:0] txCreditT;

  // Sync flags as they sit on VD[3:0] in the sync cycle, all active low
  typedef struct packed {
    logic vsyncN;
    logic clampN;
    logic hsyncN;
    logic csyncN;
  } syncFlagsT;

  // Which component the next bus cycle carries
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_RED,
    PH_GREEN,
    PH_BLUE
  } demuxPhaseT;

endpackage

`default_nettype wire
